/* issue_defines.svh */
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// register file and datapath sizes
`define NUM_REGS 32
`define XLEN 64
`define IMM_W 32
`define BUNDLE_W 133

// control word widths of the two functional units
`define XARITH_CTRL_W 8
`define XLOGIC_CTRL_W 7

// lowest bit of each field in a decoded bundle
// bit 0 of a bundle carries nothing here
`define RADDR_LSB 1
`define IMM_LSB 16
`define PIPE_LSB 48
`define SHARED_LSB 52
`define XARITH_LSB 54
`define XLOGIC_LSB 62
`define PC_LSB 69

// pipeline codes written by the decoder
`define PIPELINE_XARITH 4'd1
`define PIPELINE_XLOGIC 4'd2

`endif

/* issue_bundle_pkg.sv */
`include "issue_defines.svh"

// types for a decoded instruction bundle as it arrives from decode
package issue_bundle_pkg;

    // raw bundle, sliced with the offsets from the defines header
    typedef logic [`BUNDLE_W-1:0] bundle_t;

    // one register address, enough bits to name every register
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;

    // one bit per register
    // the scoreboard, the hazard masks and the retire pulses all use this
    typedef logic [`NUM_REGS-1:0] reg_mask_t;

    // immediate after sign extension to the full data width
    typedef logic [`XLEN-1:0] imm_t;

    typedef logic [`XLEN-1:0] pc_t;

    // pipeline code, mapped to a functional unit during unpack
    typedef logic [3:0] pipe_code_t;

    // operand selects shared by both units
    // bit 0 selects op1, bit 1 picks the immediate as op2
    typedef logic [1:0] shared_sel_t;

endpackage

/* issue_unit_pkg.sv */
`include "issue_defines.svh"

// types for the functional units fed by the issue stage
package issue_unit_pkg;

    // target unit of an instruction
    // UNIT_NONE never dispatches and stalls the stage
    typedef enum logic [1:0] {
        UNIT_NONE   = 2'd0,
        UNIT_XARITH = 2'd1,
        UNIT_XLOGIC = 2'd2
    } unit_e;

    // integer arithmetic control word
    // [1:0] opsel, [2] sub, [3] unsigned, [4] cmp_mode,
    // [5] branch_equal, [6] branch_invert, [7] word
    typedef logic [`XARITH_CTRL_W-1:0] xarith_ctrl_t;

    // integer logic control word
    // [2:0] opsel, [3] invert, [5:4] sll, [6] word
    typedef logic [`XLOGIC_CTRL_W-1:0] xlogic_ctrl_t;

endpackage

/* issue_if.sv */
`timescale 1ns/1ps

// one unpacked instruction slot, driven by bundle_unpack
interface slot_if;
    issue_bundle_pkg::reg_addr_t    rs1;
    issue_bundle_pkg::reg_addr_t    rs2;
    issue_bundle_pkg::reg_addr_t    rd;
    issue_bundle_pkg::imm_t         imm;
    issue_bundle_pkg::pc_t          pc;
    issue_unit_pkg::unit_e          unit;
    issue_bundle_pkg::shared_sel_t  shared;
    issue_unit_pkg::xarith_ctrl_t   xarith;
    issue_unit_pkg::xlogic_ctrl_t   xlogic;
    // registers that must be free in the scoreboard before this slot may go
    issue_bundle_pkg::reg_mask_t    mask;
    issue_bundle_pkg::reg_mask_t    rd_mask;

    modport producer (
        output rs1, rs2, rd, imm, pc, unit, shared, xarith, xlogic, mask, rd_mask
    );
    modport consumer (
        input  rs1, rs2, rd, imm, pc, unit, shared, xarith, xlogic, mask, rd_mask
    );
endinterface

// per-unit transfer decision from the scoreboard to the launch registers
interface dispatch_if;
    // a unit takes an instruction this cycle
    logic arith_go;
    logic logic_go;
    // the instruction comes from slot1 rather than slot0
    logic arith_from1;
    logic logic_from1;

    modport source (
        output arith_go, arith_from1, logic_go, logic_from1
    );
    modport sink (
        input  arith_go, arith_from1, logic_go, logic_from1
    );
endinterface

/* bundle_unpack.sv */
`timescale 1ns/1ps
`include "issue_defines.svh"

module bundle_unpack (
    input  issue_bundle_pkg::bundle_t i_bundle,
    slot_if.producer                  o_slot
);
    localparam int AW = $bits(issue_bundle_pkg::reg_addr_t);

    logic [`IMM_W-1:0]              imm_raw;
    issue_bundle_pkg::pipe_code_t   pipe;
    issue_bundle_pkg::reg_addr_t    rs1;
    issue_bundle_pkg::reg_addr_t    rs2;
    issue_bundle_pkg::reg_addr_t    rd;
    issue_bundle_pkg::shared_sel_t  shared;
    issue_bundle_pkg::reg_mask_t    rs2_mask;

    function automatic issue_bundle_pkg::reg_mask_t onehot(
        input issue_bundle_pkg::reg_addr_t addr
    );
        onehot = issue_bundle_pkg::reg_mask_t'(1) << addr;
    endfunction

    // register addresses sit in rs1, rs2, rd order above the unused bit 0
    assign rs1     = i_bundle[`RADDR_LSB +: AW];
    assign rs2     = i_bundle[`RADDR_LSB + AW +: AW];
    assign rd      = i_bundle[`RADDR_LSB + 2 * AW +: AW];
    assign imm_raw = i_bundle[`IMM_LSB +: `IMM_W];
    assign pipe    = i_bundle[`PIPE_LSB +: $bits(issue_bundle_pkg::pipe_code_t)];
    assign shared  = i_bundle[`SHARED_LSB +: $bits(issue_bundle_pkg::shared_sel_t)];

    assign o_slot.rs1    = rs1;
    assign o_slot.rs2    = rs2;
    assign o_slot.rd     = rd;
    assign o_slot.shared = shared;
    assign o_slot.pc     = i_bundle[`PC_LSB +: `XLEN];
    assign o_slot.xarith = i_bundle[`XARITH_LSB +: `XARITH_CTRL_W];
    assign o_slot.xlogic = i_bundle[`XLOGIC_LSB +: `XLOGIC_CTRL_W];

    // decode only carries the low immediate bits, widen them here
    assign o_slot.imm = {{(`XLEN - `IMM_W){imm_raw[`IMM_W-1]}}, imm_raw};

    always_comb begin
        case (pipe)
            `PIPELINE_XARITH: o_slot.unit = issue_unit_pkg::UNIT_XARITH;
            `PIPELINE_XLOGIC: o_slot.unit = issue_unit_pkg::UNIT_XLOGIC;
            default:          o_slot.unit = issue_unit_pkg::UNIT_NONE;
        endcase
    end

    // an immediate op2 never reads rs2, so rs2 drops out of the hazard check
    assign rs2_mask = shared[1] ? '0 : onehot(rs2);

    assign o_slot.rd_mask = onehot(rd);
    assign o_slot.mask    = onehot(rs1) | rs2_mask | onehot(rd);

endmodule

/* scoreboard_dispatch.sv */
`timescale 1ns/1ps

module scoreboard_dispatch (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_input_valid,
    slot_if.consumer                    i_slot0,
    slot_if.consumer                    i_slot1,
    input  logic                        i_xarith_ready,
    input  logic                        i_xlogic_ready,
    input  issue_bundle_pkg::reg_mask_t i_retire0,
    input  issue_bundle_pkg::reg_mask_t i_retire1,
    output logic                        o_input_ready,
    dispatch_if.source                  o_disp
);
    // a set bit marks a register written by an instruction still in flight
    issue_bundle_pkg::reg_mask_t reservation;
    issue_bundle_pkg::reg_mask_t reserve;
    issue_bundle_pkg::reg_mask_t retire;

    // slot0 already went out and only slot1 is still waiting
    logic bundle0_done;

    logic slot0_clear;
    logic slot1_clear;
    logic slot0_unit_rdy;
    logic slot1_unit_rdy;
    logic slot1_pair_hazard;
    logic slot1_unit_free;
    logic slot0_xfer;
    logic slot1_xfer;

    function automatic logic unit_ready(
        input issue_unit_pkg::unit_e unit,
        input logic                  arith_rdy,
        input logic                  logic_rdy
    );
        unit_ready = (unit == issue_unit_pkg::UNIT_XARITH && arith_rdy) ||
                     (unit == issue_unit_pkg::UNIT_XLOGIC && logic_rdy);
    endfunction

    assign slot0_unit_rdy = unit_ready(i_slot0.unit, i_xarith_ready, i_xlogic_ready);
    assign slot1_unit_rdy = unit_ready(i_slot1.unit, i_xarith_ready, i_xlogic_ready);

    // slot0 waits until none of its registers is reserved
    assign slot0_clear = i_input_valid && !bundle0_done &&
                         ((reservation & i_slot0.mask) == '0);
    assign slot0_xfer  = slot0_clear && slot0_unit_rdy;

    // while slot0 is pending its rd is not yet in the reservation, so slot1
    // may neither read nor write that register in the same cycle
    assign slot1_pair_hazard = !bundle0_done && ((i_slot1.mask & i_slot0.rd_mask) != '0);

    // each unit takes at most one instruction per cycle
    assign slot1_unit_free = bundle0_done || (i_slot1.unit != i_slot0.unit);

    // slot1 only goes together with or after slot0 to keep dispatch in order
    assign slot1_clear = i_input_valid && (slot0_xfer || bundle0_done) &&
                         slot1_unit_free && !slot1_pair_hazard &&
                         ((reservation & i_slot1.mask) == '0);
    assign slot1_xfer  = slot1_clear && slot1_unit_rdy;

    // the pair is consumed once slot1 is gone
    assign o_input_ready = slot1_xfer;

    assign o_disp.arith_go    = (slot0_xfer && i_slot0.unit == issue_unit_pkg::UNIT_XARITH) ||
                                (slot1_xfer && i_slot1.unit == issue_unit_pkg::UNIT_XARITH);
    assign o_disp.arith_from1 = slot1_xfer && i_slot1.unit == issue_unit_pkg::UNIT_XARITH;
    assign o_disp.logic_go    = (slot0_xfer && i_slot0.unit == issue_unit_pkg::UNIT_XLOGIC) ||
                                (slot1_xfer && i_slot1.unit == issue_unit_pkg::UNIT_XLOGIC);
    assign o_disp.logic_from1 = slot1_xfer && i_slot1.unit == issue_unit_pkg::UNIT_XLOGIC;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bundle0_done <= 1'b0;
        end else if (slot1_xfer) begin
            bundle0_done <= 1'b0;
        end else if (slot0_xfer) begin
            bundle0_done <= 1'b1;
        end
    end

    assign retire = i_retire0 | i_retire1;

    // register 0 is hardwired, writes to it never need tracking
    assign reserve = ((slot0_xfer ? i_slot0.rd_mask : '0) |
                      (slot1_xfer ? i_slot1.rd_mask : '0)) &
                     ~issue_bundle_pkg::reg_mask_t'(1);

    // a new reservation overrides a retire of the same register
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            reservation <= '0;
        end else begin
            reservation <= (reservation & ~retire) | reserve;
        end
    end

endmodule

/* unit_launch.sv */
`timescale 1ns/1ps

module unit_launch (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    slot_if.consumer                     i_slot0,
    slot_if.consumer                     i_slot1,
    dispatch_if.sink                     i_disp,
    output logic                         o_xarith_valid,
    output logic                         o_xarith_banksel,
    output logic                         o_xarith_op1_sel,
    output logic                         o_xarith_op2_sel,
    output issue_bundle_pkg::imm_t       o_xarith_imm,
    output issue_bundle_pkg::pc_t        o_xarith_pc,
    output issue_unit_pkg::xarith_ctrl_t o_xarith_ctrl,
    output issue_bundle_pkg::reg_addr_t  o_xarith_rd,
    output logic                         o_xlogic_valid,
    output logic                         o_xlogic_banksel,
    output logic                         o_xlogic_op2_sel,
    output issue_bundle_pkg::imm_t       o_xlogic_imm,
    output issue_unit_pkg::xlogic_ctrl_t o_xlogic_ctrl,
    output issue_bundle_pkg::reg_addr_t  o_xlogic_rd
);
    // valid is high for exactly one cycle after each accepted transfer
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_xarith_valid <= 1'b0;
            o_xlogic_valid <= 1'b0;
        end else begin
            o_xarith_valid <= i_disp.arith_go;
            o_xlogic_valid <= i_disp.logic_go;
        end
    end

    // banksel tells the unit to use read ports rs3/rs4 of slot1
    always_ff @(posedge i_clk) begin
        if (i_disp.arith_go) begin
            o_xarith_banksel <= i_disp.arith_from1;
            o_xarith_op1_sel <= i_disp.arith_from1 ? i_slot1.shared[0] : i_slot0.shared[0];
            o_xarith_op2_sel <= i_disp.arith_from1 ? i_slot1.shared[1] : i_slot0.shared[1];
            o_xarith_imm     <= i_disp.arith_from1 ? i_slot1.imm       : i_slot0.imm;
            o_xarith_pc      <= i_disp.arith_from1 ? i_slot1.pc        : i_slot0.pc;
            o_xarith_ctrl    <= i_disp.arith_from1 ? i_slot1.xarith    : i_slot0.xarith;
            o_xarith_rd      <= i_disp.arith_from1 ? i_slot1.rd        : i_slot0.rd;
        end
    end

    // the logic unit always takes op1 from rs1, so only op2 has a select
    always_ff @(posedge i_clk) begin
        if (i_disp.logic_go) begin
            o_xlogic_banksel <= i_disp.logic_from1;
            o_xlogic_op2_sel <= i_disp.logic_from1 ? i_slot1.shared[1] : i_slot0.shared[1];
            o_xlogic_imm     <= i_disp.logic_from1 ? i_slot1.imm       : i_slot0.imm;
            o_xlogic_ctrl    <= i_disp.logic_from1 ? i_slot1.xlogic    : i_slot0.xlogic;
            o_xlogic_rd      <= i_disp.logic_from1 ? i_slot1.rd        : i_slot0.rd;
        end
    end

endmodule

/* warp_issue_top.sv */
`timescale 1ns/1ps

module warp_issue_top (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_input_valid,
    output logic                         o_input_ready,
    input  issue_bundle_pkg::bundle_t    i_bundle0,
    input  issue_bundle_pkg::bundle_t    i_bundle1,
    input  issue_bundle_pkg::reg_mask_t  i_inst0_retire,
    input  issue_bundle_pkg::reg_mask_t  i_inst1_retire,
    output issue_bundle_pkg::reg_addr_t  o_rs1_addr,
    output issue_bundle_pkg::reg_addr_t  o_rs2_addr,
    output issue_bundle_pkg::reg_addr_t  o_rs3_addr,
    output issue_bundle_pkg::reg_addr_t  o_rs4_addr,
    output logic                         o_xarith_valid,
    output logic                         o_xarith_banksel,
    output logic                         o_xarith_op1_sel,
    output logic                         o_xarith_op2_sel,
    output issue_bundle_pkg::imm_t       o_xarith_imm,
    output issue_bundle_pkg::pc_t        o_xarith_pc,
    output issue_unit_pkg::xarith_ctrl_t o_xarith_ctrl,
    output issue_bundle_pkg::reg_addr_t  o_xarith_rd,
    input  logic                         i_xarith_ready,
    output logic                         o_xlogic_valid,
    output logic                         o_xlogic_banksel,
    output logic                         o_xlogic_op2_sel,
    output issue_bundle_pkg::imm_t       o_xlogic_imm,
    output issue_unit_pkg::xlogic_ctrl_t o_xlogic_ctrl,
    output issue_bundle_pkg::reg_addr_t  o_xlogic_rd,
    input  logic                         i_xlogic_ready
);
    slot_if     slot0 ();
    slot_if     slot1 ();
    dispatch_if disp ();

    bundle_unpack unpack0_i (
        .i_bundle (i_bundle0),
        .o_slot   (slot0)
    );

    bundle_unpack unpack1_i (
        .i_bundle (i_bundle1),
        .o_slot   (slot1)
    );

    scoreboard_dispatch scoreboard_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_input_valid  (i_input_valid),
        .i_slot0        (slot0),
        .i_slot1        (slot1),
        .i_xarith_ready (i_xarith_ready),
        .i_xlogic_ready (i_xlogic_ready),
        .i_retire0      (i_inst0_retire),
        .i_retire1      (i_inst1_retire),
        .o_input_ready  (o_input_ready),
        .o_disp         (disp)
    );

    unit_launch launch_i (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_slot0          (slot0),
        .i_slot1          (slot1),
        .i_disp           (disp),
        .o_xarith_valid   (o_xarith_valid),
        .o_xarith_banksel (o_xarith_banksel),
        .o_xarith_op1_sel (o_xarith_op1_sel),
        .o_xarith_op2_sel (o_xarith_op2_sel),
        .o_xarith_imm     (o_xarith_imm),
        .o_xarith_pc      (o_xarith_pc),
        .o_xarith_ctrl    (o_xarith_ctrl),
        .o_xarith_rd      (o_xarith_rd),
        .o_xlogic_valid   (o_xlogic_valid),
        .o_xlogic_banksel (o_xlogic_banksel),
        .o_xlogic_op2_sel (o_xlogic_op2_sel),
        .o_xlogic_imm     (o_xlogic_imm),
        .o_xlogic_ctrl    (o_xlogic_ctrl),
        .o_xlogic_rd      (o_xlogic_rd)
    );

    // the register file reads both slots every cycle
    // rs1/rs2 belong to bundle0 and rs3/rs4 to bundle1
    assign o_rs1_addr = slot0.rs1;
    assign o_rs2_addr = slot0.rs2;
    assign o_rs3_addr = slot1.rs1;
    assign o_rs4_addr = slot1.rs2;

endmodule

/* warp_issue_assertions.sv */
`timescale 1ns/1ps

module warp_issue_assertions (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_input_valid,
    input logic o_input_ready,
    input logic i_xarith_ready,
    input logic o_xarith_valid,
    input logic o_xlogic_valid
);
    // both units stay idle while reset is applied
    valid_low_in_reset: assert property (
        @(posedge i_clk) !i_rst_n |-> !o_xarith_valid && !o_xlogic_valid
    ) else $error("unit valid high during reset");

    // a launch needs the arithmetic unit ready on the transfer edge before it
    xarith_after_ready: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) o_xarith_valid |-> $past(i_xarith_ready)
    ) else $error("xarith valid without a ready cycle before it");

    ready_needs_valid: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !i_input_valid |-> !o_input_ready
    ) else $error("input ready high while input valid is low");

endmodule

/* tb_warp_issue.sv */
`timescale 1ns/1ps
`include "issue_defines.svh"

module tb_warp_issue;
    // six tests of about ten cycles each, plus reset
    localparam int TEST_CYCLES = 60;
    localparam int CYCLE_LIMIT = TEST_CYCLES + 40;

    logic i_clk, i_rst_n, i_input_valid, o_input_ready;
    logic i_xarith_ready, i_xlogic_ready;
    issue_bundle_pkg::bundle_t i_bundle0, i_bundle1;
    issue_bundle_pkg::reg_mask_t i_inst0_retire, i_inst1_retire;
    issue_bundle_pkg::reg_addr_t o_rs1_addr, o_rs2_addr, o_rs3_addr, o_rs4_addr;
    issue_bundle_pkg::reg_addr_t o_xarith_rd, o_xlogic_rd;
    logic o_xarith_valid, o_xarith_banksel, o_xarith_op1_sel, o_xarith_op2_sel;
    logic o_xlogic_valid, o_xlogic_banksel, o_xlogic_op2_sel;
    issue_bundle_pkg::imm_t o_xarith_imm, o_xlogic_imm;
    issue_bundle_pkg::pc_t o_xarith_pc;
    issue_unit_pkg::xarith_ctrl_t o_xarith_ctrl;
    issue_unit_pkg::xlogic_ctrl_t o_xlogic_ctrl;

    // fields of the pair on the input, index 0 is bundle0
    issue_bundle_pkg::reg_addr_t slot_rs1 [2];
    issue_bundle_pkg::reg_addr_t slot_rs2 [2];
    issue_bundle_pkg::reg_addr_t slot_rd [2];
    logic [`IMM_W-1:0] slot_imm [2];
    issue_bundle_pkg::pipe_code_t slot_pipe [2];
    issue_bundle_pkg::shared_sel_t slot_shared [2];
    issue_unit_pkg::xarith_ctrl_t slot_xa [2];
    issue_unit_pkg::xlogic_ctrl_t slot_xl [2];
    issue_bundle_pkg::pc_t slot_pc [2];

    // expected unit outputs, index 0 is xarith and index 1 is xlogic
    logic exp_valid [2];
    logic exp_bank [2];
    logic exp_op1 [2];
    logic exp_op2 [2];
    issue_bundle_pkg::reg_addr_t exp_rd [2];
    issue_bundle_pkg::imm_t exp_imm [2];
    issue_bundle_pkg::pc_t exp_pc [2];
    logic [7:0] exp_ctrl [2];

    // read addresses seen on the ports and the ones the pair carries
    logic [19:0] seen_rs;
    logic [19:0] exp_rs;

    issue_bundle_pkg::reg_mask_t shadow_res;
    logic shadow_done, pred_ready, seen_ready;
    integer seed = 32'h2098;
    int accepts = 0, accept_base = 0, cycles = 0;
    int checks = 0, errors = 0, err_mark = 0, tests = 0;

    warp_issue_top dut_i (.*);

    bind warp_issue_top warp_issue_assertions assertions_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_input_valid  (i_input_valid),
        .o_input_ready  (o_input_ready),
        .i_xarith_ready (i_xarith_ready),
        .o_xarith_valid (o_xarith_valid),
        .o_xlogic_valid (o_xlogic_valid)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("error at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    // sources come from r16..r31 so they never meet a destination of a test
    function automatic issue_bundle_pkg::reg_addr_t rand_src();
        logic [31:0] r;
        r = rand_word();
        return 5'd16 + {1'b0, r[3:0]};
    endfunction

    function automatic issue_bundle_pkg::reg_mask_t hazard_mask(input int k);
        issue_bundle_pkg::reg_mask_t m;
        m = '0;
        m[slot_rs1[k]] = 1'b1;
        if (!slot_shared[k][1]) m[slot_rs2[k]] = 1'b1;
        m[slot_rd[k]] = 1'b1;
        return m;
    endfunction

    function automatic logic unit_is_ready(input issue_bundle_pkg::pipe_code_t pipe);
        return (pipe == `PIPELINE_XARITH && i_xarith_ready) ||
               (pipe == `PIPELINE_XLOGIC && i_xlogic_ready);
    endfunction

    // which slots transfer at the coming edge, bit 0 for slot0 and bit 1 for slot1
    function automatic logic [1:0] predict_xfer(input issue_bundle_pkg::reg_mask_t res,
                                                input logic done);
        issue_bundle_pkg::reg_mask_t m0;
        issue_bundle_pkg::reg_mask_t m1;
        logic s0;
        logic s1;
        m0 = hazard_mask(0);
        m1 = hazard_mask(1);
        s0 = i_input_valid && !done && ((res & m0) == '0) && unit_is_ready(slot_pipe[0]);
        s1 = i_input_valid && (s0 || done) && (done || slot_pipe[1] != slot_pipe[0]) &&
             (done || !m1[slot_rd[0]]) && ((res & m1) == '0) && unit_is_ready(slot_pipe[1]);
        return {s1, s0};
    endfunction

    task automatic expect_slot(input int k);
        int u;
        u = (slot_pipe[k] == `PIPELINE_XLOGIC) ? 1 : 0;
        exp_valid[u] = 1'b1;
        exp_bank[u] = (k == 1);
        exp_rd[u] = slot_rd[k];
        exp_imm[u] = 64'($signed(slot_imm[k]));
        exp_pc[u] = slot_pc[k];
        exp_ctrl[u] = (u == 1) ? {1'b0, slot_xl[k]} : slot_xa[k];
        exp_op1[u] = slot_shared[k][0];
        exp_op2[u] = slot_shared[k][1];
    endtask

    always @(posedge i_clk) begin : model
        logic [1:0] xfer;
        exp_valid[0] = 1'b0;
        exp_valid[1] = 1'b0;
        if (!i_rst_n) begin
            shadow_res = '0;
            shadow_done = 1'b0;
            pred_ready = 1'b0;
            seen_ready = 1'b0;
            seen_rs = '0;
            exp_rs = '0;
        end else begin
            xfer = predict_xfer(shadow_res, shadow_done);
            pred_ready = xfer[1];
            seen_ready = o_input_ready;
            seen_rs = {o_rs1_addr, o_rs2_addr, o_rs3_addr, o_rs4_addr};
            exp_rs = {slot_rs1[0], slot_rs2[0], slot_rs1[1], slot_rs2[1]};
            if (i_input_valid && o_input_ready) accepts = accepts + 1;
            shadow_res = shadow_res & ~(i_inst0_retire | i_inst1_retire);
            for (int k = 0; k < 2; k++) begin
                if (xfer[k]) begin
                    expect_slot(k);
                    if (slot_rd[k] != 5'd0) shadow_res[slot_rd[k]] = 1'b1;
                end
            end
            if (xfer[1]) shadow_done = 1'b0;
            else if (xfer[0]) shadow_done = 1'b1;
        end
    end

    always @(negedge i_clk) begin
        if (i_rst_n) begin
            check(64'(seen_ready), 64'(pred_ready), "input ready");
            check(64'(seen_rs), 64'(exp_rs), "read addresses");
            check(64'(o_xarith_valid), 64'(exp_valid[0]), "xarith valid");
            if (o_xarith_valid && exp_valid[0]) begin
                check(64'(o_xarith_banksel), 64'(exp_bank[0]), "xarith banksel");
                check(64'(o_xarith_rd), 64'(exp_rd[0]), "xarith rd");
                check(o_xarith_imm, exp_imm[0], "xarith imm");
                check(o_xarith_pc, exp_pc[0], "xarith pc");
                check(64'(o_xarith_ctrl), 64'(exp_ctrl[0]), "xarith ctrl");
                check(64'(o_xarith_op1_sel), 64'(exp_op1[0]), "xarith op1 select");
                check(64'(o_xarith_op2_sel), 64'(exp_op2[0]), "xarith op2 select");
            end
            check(64'(o_xlogic_valid), 64'(exp_valid[1]), "xlogic valid");
            if (o_xlogic_valid && exp_valid[1]) begin
                check(64'(o_xlogic_banksel), 64'(exp_bank[1]), "xlogic banksel");
                check(64'(o_xlogic_rd), 64'(exp_rd[1]), "xlogic rd");
                check(o_xlogic_imm, exp_imm[1], "xlogic imm");
                check(64'(o_xlogic_ctrl), 64'(exp_ctrl[1]), "xlogic ctrl");
                check(64'(o_xlogic_op2_sel), 64'(exp_op2[1]), "xlogic op2 select");
            end
        end
    end

    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic issue_bundle_pkg::bundle_t pack_bundle(input int k);
        issue_bundle_pkg::bundle_t b;
        b = '0;
        b[`RADDR_LSB +: 5] = slot_rs1[k];
        b[`RADDR_LSB + 5 +: 5] = slot_rs2[k];
        b[`RADDR_LSB + 10 +: 5] = slot_rd[k];
        b[`IMM_LSB +: `IMM_W] = slot_imm[k];
        b[`PIPE_LSB +: 4] = slot_pipe[k];
        b[`SHARED_LSB +: 2] = slot_shared[k];
        b[`XARITH_LSB +: `XARITH_CTRL_W] = slot_xa[k];
        b[`XLOGIC_LSB +: `XLOGIC_CTRL_W] = slot_xl[k];
        b[`PC_LSB +: `XLEN] = slot_pc[k];
        return b;
    endfunction

    task automatic set_slot(input int k, input issue_bundle_pkg::pipe_code_t pipe,
                            input issue_bundle_pkg::reg_addr_t rs1,
                            input issue_bundle_pkg::reg_addr_t rs2,
                            input issue_bundle_pkg::reg_addr_t rd,
                            input issue_bundle_pkg::shared_sel_t sh);
        logic [31:0] r;
        slot_pipe[k] = pipe;
        slot_rs1[k] = rs1;
        slot_rs2[k] = rs2;
        slot_rd[k] = rd;
        slot_shared[k] = sh;
        slot_imm[k] = rand_word();
        r = rand_word();
        slot_pc[k] = {32'h0000_0000, r[31:2], 2'b00};
        r = rand_word();
        slot_xa[k] = r[7:0];
        slot_xl[k] = r[14:8];
    endtask

    // the stimulus tasks below start and end on a falling edge
    task automatic present_pair();
        i_bundle0 = pack_bundle(0);
        i_bundle1 = pack_bundle(1);
        i_input_valid = 1'b1;
        accept_base = accepts;
    endtask

    task automatic wait_accept();
        while (accepts == accept_base) @(negedge i_clk);
        i_input_valid = 1'b0;
    endtask

    task automatic pulse_retire(input issue_bundle_pkg::reg_mask_t m0,
                                input issue_bundle_pkg::reg_mask_t m1);
        i_inst0_retire = m0;
        i_inst1_retire = m1;
        @(negedge i_clk);
        i_inst0_retire = '0;
        i_inst1_retire = '0;
    endtask

    task automatic end_test(input string name);
        int fails;
        repeat (2) @(negedge i_clk);
        #10;
        fails = errors - err_mark;
        err_mark = errors;
        tests = tests + 1;
        $display("test %0d %s: %s", tests, name, (fails == 0) ? "ok" : "mismatch");
        @(negedge i_clk);
    endtask

    initial begin
        i_rst_n = 1'b0;
        i_input_valid = 1'b0;
        i_bundle0 = '0;
        i_bundle1 = '0;
        i_inst0_retire = '0;
        i_inst1_retire = '0;
        i_xarith_ready = 1'b1;
        i_xlogic_ready = 1'b1;
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        set_slot(0, `PIPELINE_XARITH, rand_src(), rand_src(), 5'd5, 2'b10);
        set_slot(1, `PIPELINE_XLOGIC, rand_src(), rand_src(), 5'd6, 2'b01);
        slot_imm[0][31] = 1'b1;
        slot_imm[1][31] = 1'b1;
        present_pair();
        wait_accept();
        pulse_retire(32'h0000_0060, '0);
        end_test("independent pair");

        set_slot(0, `PIPELINE_XARITH, rand_src(), rand_src(), 5'd7, 2'b00);
        set_slot(1, `PIPELINE_XARITH, rand_src(), rand_src(), 5'd8, 2'b11);
        present_pair();
        wait_accept();
        pulse_retire(32'h0000_0080, 32'h0000_0100);
        end_test("two xarith");

        set_slot(0, `PIPELINE_XARITH, rand_src(), rand_src(), 5'd10, 2'b00);
        set_slot(1, `PIPELINE_XLOGIC, rand_src(), rand_src(), 5'd11, 2'b00);
        present_pair();
        wait_accept();
        // r10 is read and r11 only sits in an rs2 field that selects the immediate
        set_slot(0, `PIPELINE_XARITH, 5'd10, rand_src(), 5'd12, 2'b00);
        set_slot(1, `PIPELINE_XLOGIC, rand_src(), 5'd11, 5'd13, 2'b10);
        present_pair();
        repeat (3) @(negedge i_clk);
        pulse_retire(32'h0000_0400, '0);
        wait_accept();
        pulse_retire(32'h0000_0800, 32'h0000_3000);
        end_test("raw hazard");

        set_slot(0, `PIPELINE_XARITH, rand_src(), rand_src(), 5'd14, 2'b00);
        set_slot(1, `PIPELINE_XLOGIC, rand_src(), rand_src(), 5'd14, 2'b00);
        present_pair();
        repeat (3) @(negedge i_clk);
        pulse_retire('0, 32'h0000_4000);
        wait_accept();
        pulse_retire(32'h0000_4000, '0);
        end_test("same rd");

        i_xlogic_ready = 1'b0;
        set_slot(0, `PIPELINE_XLOGIC, rand_src(), rand_src(), 5'd15, 2'b00);
        set_slot(1, `PIPELINE_XARITH, rand_src(), rand_src(), 5'd9, 2'b01);
        present_pair();
        repeat (4) @(negedge i_clk);
        i_xlogic_ready = 1'b1;
        wait_accept();
        pulse_retire(32'h0000_8000, 32'h0000_0200);
        end_test("back-pressure");

        set_slot(0, `PIPELINE_XARITH, rand_src(), rand_src(), 5'd0, 2'b00);
        set_slot(1, `PIPELINE_XLOGIC, rand_src(), rand_src(), 5'd3, 2'b00);
        present_pair();
        wait_accept();
        set_slot(0, `PIPELINE_XARITH, 5'd0, 5'd0, 5'd4, 2'b00);
        set_slot(1, `PIPELINE_XLOGIC, 5'd0, rand_src(), 5'd2, 2'b00);
        present_pair();
        wait_accept();
        pulse_retire(32'h0000_0018, 32'h0000_0004);
        end_test("register 0");

        #10;
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
issue_bundle_pkg.sv
issue_unit_pkg.sv
issue_if.sv
bundle_unpack.sv
scoreboard_dispatch.sv
unit_launch.sv
warp_issue_top.sv
warp_issue_assertions.sv
tb_warp_issue.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_warp_issue \
    -f flist.f > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_warp_issue > sim.log 2>&1
grep -q "Simulation failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "FAIL, run aborted"; exit 1; }
echo "PASS"
